//--- hdl/exu_pkg.sv
`default_nettype none

package exu_pkg;

  ////////////////////
  // Widths and sizes
  localparam int XLEN       = 32;
  localparam int RFIDX_W    = 5;
  localparam int RF_NUM     = 32;
  localparam int OITF_DEPTH = 2;
  localparam int ITAG_W     = 1;  // Wide enough to index OITF_DEPTH entries

  ////////////////////
  // Decoded opcode subset
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;

  localparam logic [2:0] F3_ADD = 3'b000;  // ADD, SUB, ADDI
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_LW  = 3'b010;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  ////////////////////
  // Stage payloads
  typedef struct packed {
    alu_op_e              alu_op;
    logic                 use_imm;  // op2 taken from the immediate
    logic                 load;
    logic                 rdwen;
    logic [RFIDX_W-1:0]   rdidx;
    logic                 rs1en;
    logic                 rs2en;
  } dec_info_t;

  typedef struct packed {
    logic [XLEN-1:0]      rs1;
    logic [XLEN-1:0]      rs2;
    logic [XLEN-1:0]      imm;
    dec_info_t            info;
    logic [ITAG_W-1:0]    itag;
  } disp_pkt_t;

  typedef struct packed {
    logic [RFIDX_W-1:0]   rdidx;
    logic [XLEN-1:0]      data;
  } wbck_t;

  typedef struct packed {
    logic [XLEN-1:0]      addr;
    logic [ITAG_W-1:0]    itag;
  } agu_cmd_t;

  typedef struct packed {
    logic [XLEN-1:0]      data;
    logic [ITAG_W-1:0]    itag;
    logic                 err;  // Bus error suppresses the write-back
  } lsu_rsp_t;

endpackage

`default_nettype wire

//--- hdl/exu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module exu_decode import exu_pkg::*; (
  input  wire logic [XLEN-1:0]    i_ir,
  output logic      [RFIDX_W-1:0] o_rs1idx,
  output logic      [RFIDX_W-1:0] o_rs2idx,
  output logic      [XLEN-1:0]    o_imm,
  output dec_info_t               o_info
);

  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [RFIDX_W-1:0] rdidx;
  logic               legal;
  logic               wen;

  assign opcode = i_ir[6:0];
  assign rdidx  = i_ir[11:7];
  assign funct3 = i_ir[14:12];
  assign funct7 = i_ir[31:25];

  assign o_rs1idx = i_ir[19:15];
  assign o_rs2idx = i_ir[24:20];
  assign o_imm    = {{(XLEN-12){i_ir[31]}}, i_ir[31:20]};  // Sign-extended I-type immediate

  always_comb begin
    o_info = '0;
    legal  = 1'b0;
    wen    = 1'b0;
    case (opcode)
      OPC_OP: begin
        o_info.rs1en = 1'b1;
        o_info.rs2en = 1'b1;
        wen          = 1'b1;
        legal        = 1'b1;
        if (funct7 == F7_SUB && funct3 == F3_ADD) begin
          o_info.alu_op = ALU_SUB;
        end else if (funct7 != F7_BASE) begin
          legal = 1'b0;
        end else begin
          case (funct3)
            F3_ADD:  o_info.alu_op = ALU_ADD;
            F3_SLT:  o_info.alu_op = ALU_SLT;
            F3_XOR:  o_info.alu_op = ALU_XOR;
            F3_OR:   o_info.alu_op = ALU_OR;
            F3_AND:  o_info.alu_op = ALU_AND;
            default: legal = 1'b0;
          endcase
        end
      end
      OPC_OPIMM: begin
        o_info.rs1en   = 1'b1;
        o_info.use_imm = 1'b1;
        wen            = 1'b1;
        legal          = 1'b1;
        case (funct3)
          F3_ADD:  o_info.alu_op = ALU_ADD;
          F3_XOR:  o_info.alu_op = ALU_XOR;
          F3_OR:   o_info.alu_op = ALU_OR;
          F3_AND:  o_info.alu_op = ALU_AND;
          default: legal = 1'b0;  // SLTI and shifts are not decoded
        endcase
      end
      OPC_LOAD: begin
        o_info.rs1en   = 1'b1;
        o_info.use_imm = 1'b1;  // Address is rs1 + imm
        o_info.load    = 1'b1;
        o_info.alu_op  = ALU_ADD;
        wen            = 1'b1;
        legal          = (funct3 == F3_LW);
      end
      default: legal = 1'b0;
    endcase

    // Illegal encodings travel on as bubbles
    o_info.rs1en = o_info.rs1en & legal;
    o_info.rs2en = o_info.rs2en & legal;
    o_info.load  = o_info.load & legal;
    o_info.rdidx = rdidx;
    o_info.rdwen = wen & legal & (rdidx != '0);
  end

endmodule

`default_nettype wire

//--- hdl/exu_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module exu_regfile import exu_pkg::*; (
  input  wire logic               clk,
  input  wire logic               i_rst,
  input  wire logic [RFIDX_W-1:0] i_rs1idx,
  input  wire logic [RFIDX_W-1:0] i_rs2idx,
  output logic      [XLEN-1:0]    o_rs1,
  output logic      [XLEN-1:0]    o_rs2,
  input  wire logic               i_wena,
  input  wire wbck_t              i_wbck
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:RF_NUM-1];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 1; i < RF_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wena && i_wbck.rdidx != '0) begin
      regs[i_wbck.rdidx] <= i_wbck.data;
    end
  end

  assign o_rs1 = (i_rs1idx == '0) ? '0 : regs[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : regs[i_rs2idx];

endmodule

`default_nettype wire

//--- hdl/exu_oitf.sv
`timescale 1ns/1ns
`default_nettype none

module exu_oitf import exu_pkg::*; (
  input  wire logic               clk,
  input  wire logic               i_rst,
  // Allocation side
  input  wire logic               i_dis_ena,
  input  wire logic [RFIDX_W-1:0] i_dis_rdidx,
  output logic      [ITAG_W-1:0]  o_dis_ptr,
  output logic                    o_full,
  // Retire side
  input  wire logic               i_ret_ena,
  output logic      [ITAG_W-1:0]  o_ret_ptr,
  output logic      [RFIDX_W-1:0] o_ret_rdidx,
  // Hazard lookup
  input  wire logic [RFIDX_W-1:0] i_rs1idx,
  input  wire logic [RFIDX_W-1:0] i_rs2idx,
  input  wire logic [RFIDX_W-1:0] i_rdidx,
  input  wire logic               i_rs1en,
  input  wire logic               i_rs2en,
  output logic                    o_match,
  output logic                    o_empty
);

  logic [OITF_DEPTH-1:0] vld_q;
  logic [RFIDX_W-1:0]    rd_q [OITF_DEPTH];
  logic [ITAG_W-1:0]     alc_ptr;
  logic [ITAG_W-1:0]     ret_ptr;
  logic                  alc_flg;  // Wrap bits tell full from empty
  logic                  ret_flg;
  logic [OITF_DEPTH-1:0] hit;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      alc_ptr <= '0;
      alc_flg <= 1'b0;
      ret_ptr <= '0;
      ret_flg <= 1'b0;
      vld_q   <= '0;
    end else begin
      if (i_dis_ena) begin
        vld_q[alc_ptr] <= 1'b1;
        if (alc_ptr == ITAG_W'(OITF_DEPTH-1)) begin
          alc_ptr <= '0;
          alc_flg <= ~alc_flg;
        end else begin
          alc_ptr <= alc_ptr + 1'b1;
        end
      end
      if (i_ret_ena) begin
        vld_q[ret_ptr] <= 1'b0;
        if (ret_ptr == ITAG_W'(OITF_DEPTH-1)) begin
          ret_ptr <= '0;
          ret_flg <= ~ret_flg;
        end else begin
          ret_ptr <= ret_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_dis_ena) rd_q[alc_ptr] <= i_dis_rdidx;
  end

  // Entries with rd x0 never block anything
  always_comb begin
    for (int i = 0; i < OITF_DEPTH; i++) begin
      hit[i] = vld_q[i] & (rd_q[i] != '0) &
               ((i_rs1en & (rd_q[i] == i_rs1idx)) |
                (i_rs2en & (rd_q[i] == i_rs2idx)) |
                (rd_q[i] == i_rdidx));
    end
  end

  assign o_match     = |hit;
  assign o_empty     = (alc_ptr == ret_ptr) & (alc_flg == ret_flg);
  assign o_full      = (alc_ptr == ret_ptr) & (alc_flg != ret_flg);
  assign o_dis_ptr   = alc_ptr;
  assign o_ret_ptr   = ret_ptr;
  assign o_ret_rdidx = rd_q[ret_ptr];

endmodule

`default_nettype wire

//--- hdl/exu_disp.sv
`timescale 1ns/1ns
`default_nettype none

module exu_disp import exu_pkg::*; (
  input  wire logic               i_valid,
  output logic                    o_ready,
  input  wire dec_info_t          i_info,
  input  wire logic [RFIDX_W-1:0] i_rs1idx,
  input  wire logic [RFIDX_W-1:0] i_rs2idx,
  input  wire logic [XLEN-1:0]    i_imm,
  input  wire logic [XLEN-1:0]    i_rs1,
  input  wire logic [XLEN-1:0]    i_rs2,
  // OITF status
  input  wire logic               i_oitf_match,
  input  wire logic               i_oitf_full,
  input  wire logic [ITAG_W-1:0]  i_oitf_ptr,
  output logic                    o_oitf_ena,
  // Result still held in the ALU stage
  input  wire logic [RFIDX_W-1:0] i_alu_busy_rd,
  input  wire logic               i_alu_busy_vld,
  // To ALU stage
  output logic                    o_disp_valid,
  input  wire logic               i_disp_ready,
  output disp_pkt_t               o_disp_pkt
);

  logic alu_hazard;
  logic stall;

  // The pending ALU result is not in the register file yet
  assign alu_hazard = i_alu_busy_vld &
                      ((i_info.rs1en & (i_rs1idx == i_alu_busy_rd)) |
                       (i_info.rs2en & (i_rs2idx == i_alu_busy_rd)) |
                       (i_info.rdidx == i_alu_busy_rd));

  assign stall = i_oitf_match | (i_info.load & i_oitf_full) | alu_hazard;

  assign o_disp_valid = i_valid & ~stall;
  assign o_ready      = o_disp_valid & i_disp_ready;
  assign o_oitf_ena   = o_ready & i_info.load;  // One entry per dispatched load

  always_comb begin
    o_disp_pkt.rs1  = i_rs1;
    o_disp_pkt.rs2  = i_rs2;
    o_disp_pkt.imm  = i_imm;
    o_disp_pkt.info = i_info;
    o_disp_pkt.itag = i_oitf_ptr;
  end

endmodule

`default_nettype wire

//--- hdl/exu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module exu_alu import exu_pkg::*; (
  input  wire logic               clk,
  input  wire logic               i_rst,
  input  wire logic               i_disp_valid,
  output logic                    o_disp_ready,
  input  wire disp_pkt_t          i_disp_pkt,
  output logic                    o_busy_vld,
  output logic      [RFIDX_W-1:0] o_busy_rd,
  // Result to write-back
  output logic                    o_wbck_valid,
  output wbck_t                   o_wbck,
  input  wire logic               i_wbck_grant,
  // Load command to the load unit
  output logic                    o_agu_valid,
  output agu_cmd_t                o_agu_cmd,
  input  wire logic               i_agu_ready
);

  logic [XLEN-1:0]    op2;
  logic [XLEN-1:0]    res;
  logic               take;
  logic               drain;
  logic               r_valid;
  logic               r_load;
  logic [RFIDX_W-1:0] r_rdidx;
  logic [XLEN-1:0]    r_data;  // Result, or load address
  logic [ITAG_W-1:0]  r_itag;

  assign op2 = i_disp_pkt.info.use_imm ? i_disp_pkt.imm : i_disp_pkt.rs2;

  always_comb begin
    case (i_disp_pkt.info.alu_op)
      ALU_SUB: res = i_disp_pkt.rs1 - op2;
      ALU_AND: res = i_disp_pkt.rs1 & op2;
      ALU_OR:  res = i_disp_pkt.rs1 | op2;
      ALU_XOR: res = i_disp_pkt.rs1 ^ op2;
      ALU_SLT: res = {{(XLEN-1){1'b0}}, $signed(i_disp_pkt.rs1) < $signed(op2)};
      default: res = i_disp_pkt.rs1 + op2;  // ADD and load address
    endcase
  end

  ////////////////////
  // Output register
  assign drain        = r_valid & (r_load ? i_agu_ready : i_wbck_grant);
  assign o_disp_ready = ~r_valid | drain;
  assign take         = i_disp_valid & o_disp_ready;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      r_valid <= 1'b0;
    end else if (take) begin
      // Packets with nothing to do are dropped here
      r_valid <= i_disp_pkt.info.load | i_disp_pkt.info.rdwen;
    end else if (drain) begin
      r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      r_load  <= i_disp_pkt.info.load;
      r_rdidx <= i_disp_pkt.info.rdidx;
      r_data  <= res;
      r_itag  <= i_disp_pkt.itag;
    end
  end

  assign o_wbck_valid   = r_valid & ~r_load;
  assign o_wbck.rdidx   = r_rdidx;
  assign o_wbck.data    = r_data;
  assign o_agu_valid    = r_valid & r_load;
  assign o_agu_cmd.addr = r_data;
  assign o_agu_cmd.itag = r_itag;
  assign o_busy_vld     = o_wbck_valid;  // Only results block dispatch
  assign o_busy_rd      = r_rdidx;

endmodule

`default_nettype wire

//--- hdl/exu_wbck.sv
`timescale 1ns/1ns
`default_nettype none

module exu_wbck import exu_pkg::*; (
  // Load responses
  input  wire logic               i_lsu_valid,
  output logic                    o_lsu_ready,
  input  wire lsu_rsp_t           i_lsu_rsp,
  // OITF head
  input  wire logic [ITAG_W-1:0]  i_ret_ptr,
  input  wire logic [RFIDX_W-1:0] i_ret_rdidx,
  // ALU results
  input  wire logic               i_alu_valid,
  input  wire wbck_t              i_alu_wbck,
  output logic                    o_alu_grant,
  output logic                    o_ret_ena,
  // Register file port
  output logic                    o_rf_wena,
  output wbck_t                   o_rf_wbck
);

  logic lsu_hit;

  // Only the oldest outstanding load may answer
  assign lsu_hit     = i_lsu_valid & (i_lsu_rsp.itag == i_ret_ptr);
  assign o_lsu_ready = lsu_hit;
  assign o_ret_ena   = lsu_hit;  // Retires on error too

  assign o_alu_grant = i_alu_valid & ~lsu_hit;  // Long pipe wins

  assign o_rf_wena = lsu_hit ? (~i_lsu_rsp.err & (i_ret_rdidx != '0)) : i_alu_valid;

  always_comb begin
    o_rf_wbck = i_alu_wbck;
    if (lsu_hit) begin
      o_rf_wbck.rdidx = i_ret_rdidx;
      o_rf_wbck.data  = i_lsu_rsp.data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/exu.sv
`timescale 1ns/1ns
`default_nettype none

module exu import exu_pkg::*; (
  input  wire logic            clk,
  input  wire logic            i_rst,
  // Instruction in
  input  wire logic            i_valid,
  output logic                 o_ready,
  input  wire logic [XLEN-1:0] i_ir,
  // Load command
  output logic                 o_agu_valid,
  output agu_cmd_t             o_agu_cmd,
  input  wire logic            i_agu_ready,
  // Load response
  input  wire logic            i_lsu_valid,
  output logic                 o_lsu_ready,
  input  wire lsu_rsp_t        i_lsu_rsp,
  // Register write
  output logic                 o_rf_wbck_ena,
  output wbck_t                o_rf_wbck,
  output logic                 o_oitf_empty,
  output logic                 o_exu_active
);

  logic [RFIDX_W-1:0] dec_rs1idx;
  logic [RFIDX_W-1:0] dec_rs2idx;
  logic [XLEN-1:0]    dec_imm;
  dec_info_t          dec_info;
  logic [XLEN-1:0]    rf_rs1;
  logic [XLEN-1:0]    rf_rs2;

  logic               oitf_ena;
  logic [ITAG_W-1:0]  oitf_dis_ptr;
  logic               oitf_full;
  logic               oitf_match;
  logic               oitf_ret_ena;
  logic [ITAG_W-1:0]  oitf_ret_ptr;
  logic [RFIDX_W-1:0] oitf_ret_rdidx;

  logic               disp_valid;
  logic               disp_ready;
  disp_pkt_t          disp_pkt;
  logic               alu_busy_vld;
  logic [RFIDX_W-1:0] alu_busy_rd;
  logic               alu_wbck_valid;
  wbck_t              alu_wbck;
  logic               alu_grant;

  ////////////////////
  // Decode and operands
  exu_decode u_exu_decode (
    .i_ir     (i_ir),
    .o_rs1idx (dec_rs1idx),
    .o_rs2idx (dec_rs2idx),
    .o_imm    (dec_imm),
    .o_info   (dec_info)
  );

  exu_regfile u_exu_regfile (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_rs1idx (dec_rs1idx),
    .i_rs2idx (dec_rs2idx),
    .o_rs1    (rf_rs1),
    .o_rs2    (rf_rs2),
    .i_wena   (o_rf_wbck_ena),
    .i_wbck   (o_rf_wbck)
  );

  exu_oitf u_exu_oitf (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_dis_ena   (oitf_ena),
    .i_dis_rdidx (dec_info.rdidx),
    .o_dis_ptr   (oitf_dis_ptr),
    .o_full      (oitf_full),
    .i_ret_ena   (oitf_ret_ena),
    .o_ret_ptr   (oitf_ret_ptr),
    .o_ret_rdidx (oitf_ret_rdidx),
    .i_rs1idx    (dec_rs1idx),
    .i_rs2idx    (dec_rs2idx),
    .i_rdidx     (dec_info.rdidx),
    .i_rs1en     (dec_info.rs1en),
    .i_rs2en     (dec_info.rs2en),
    .o_match     (oitf_match),
    .o_empty     (o_oitf_empty)
  );

  ////////////////////
  // Dispatch and ALU
  exu_disp u_exu_disp (
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .i_info         (dec_info),
    .i_rs1idx       (dec_rs1idx),
    .i_rs2idx       (dec_rs2idx),
    .i_imm          (dec_imm),
    .i_rs1          (rf_rs1),
    .i_rs2          (rf_rs2),
    .i_oitf_match   (oitf_match),
    .i_oitf_full    (oitf_full),
    .i_oitf_ptr     (oitf_dis_ptr),
    .o_oitf_ena     (oitf_ena),
    .i_alu_busy_rd  (alu_busy_rd),
    .i_alu_busy_vld (alu_busy_vld),
    .o_disp_valid   (disp_valid),
    .i_disp_ready   (disp_ready),
    .o_disp_pkt     (disp_pkt)
  );

  exu_alu u_exu_alu (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_disp_valid (disp_valid),
    .o_disp_ready (disp_ready),
    .i_disp_pkt   (disp_pkt),
    .o_busy_vld   (alu_busy_vld),
    .o_busy_rd    (alu_busy_rd),
    .o_wbck_valid (alu_wbck_valid),
    .o_wbck       (alu_wbck),
    .i_wbck_grant (alu_grant),
    .o_agu_valid  (o_agu_valid),
    .o_agu_cmd    (o_agu_cmd),
    .i_agu_ready  (i_agu_ready)
  );

  exu_wbck u_exu_wbck (
    .i_lsu_valid (i_lsu_valid),
    .o_lsu_ready (o_lsu_ready),
    .i_lsu_rsp   (i_lsu_rsp),
    .i_ret_ptr   (oitf_ret_ptr),
    .i_ret_rdidx (oitf_ret_rdidx),
    .i_alu_valid (alu_wbck_valid),
    .i_alu_wbck  (alu_wbck),
    .o_alu_grant (alu_grant),
    .o_ret_ena   (oitf_ret_ena),
    .o_rf_wena   (o_rf_wbck_ena),
    .o_rf_wbck   (o_rf_wbck)
  );

  assign o_exu_active = ~o_oitf_empty | i_valid;  // Loads in flight keep the stage awake

endmodule

`default_nettype wire

//--- testbench/exu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module exu_properties import exu_pkg::*; (
  input wire logic     clk,
  input wire logic     i_rst,
  input wire logic     o_agu_valid,
  input wire agu_cmd_t o_agu_cmd,
  input wire logic     i_agu_ready,
  input wire logic     o_rf_wbck_ena,
  input wire wbck_t    o_rf_wbck,
  input wire logic     o_oitf_empty
);

  // Command held until the load unit takes it
  agu_hold: assert property (@(posedge clk) disable iff (i_rst)
    (o_agu_valid && !i_agu_ready) |=> (o_agu_valid && $stable(o_agu_cmd)))
    else $error("load command dropped or changed while stalled");

  no_x0_write: assert property (@(posedge clk) disable iff (i_rst)
    o_rf_wbck_ena |-> (o_rf_wbck.rdidx != '0))
    else $error("register write to x0");

  empty_after_reset: assert property (@(posedge clk)
    i_rst |=> o_oitf_empty)
    else $error("OITF not empty after reset");

endmodule

bind exu exu_properties u_exu_properties (
  .clk           (clk),
  .i_rst         (i_rst),
  .o_agu_valid   (o_agu_valid),
  .o_agu_cmd     (o_agu_cmd),
  .i_agu_ready   (i_agu_ready),
  .o_rf_wbck_ena (o_rf_wbck_ena),
  .o_rf_wbck     (o_rf_wbck),
  .o_oitf_empty  (o_oitf_empty)
);

`default_nettype wire

//--- testbench/tb_exu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exu import exu_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 10;
  localparam int N_STEPS    = 26;
  localparam int WD_CYCLES  = RST_CYCLES + N_STEPS * 40;
  localparam logic [XLEN-1:0] LOAD_XOR = 32'h5a5a_0f0f;  // Load data is address ^ LOAD_XOR

  typedef struct packed {
    logic [XLEN-1:0] ir;
    logic            err;  // Load answered with a bus error
    logic            wen;  // Register write expected
  } step_t;

  logic            clk;
  logic            i_rst;
  logic            i_valid;
  logic            o_ready;
  logic [XLEN-1:0] i_ir;
  logic            o_agu_valid;
  agu_cmd_t        o_agu_cmd;
  logic            i_agu_ready;
  logic            i_lsu_valid;
  logic            o_lsu_ready;
  lsu_rsp_t        i_lsu_rsp;
  logic            o_rf_wbck_ena;
  wbck_t           o_rf_wbck;
  logic            o_oitf_empty;
  logic            o_exu_active;

  step_t           steps [N_STEPS];
  int              n_built = 0;
  logic [XLEN-1:0] model_rf [RF_NUM];
  wbck_t           exp_q [$];      // Pending writes in program order
  agu_cmd_t        agu_exp_q [$];
  logic            err_q [$];
  lsu_rsp_t        rsp_q [$];      // Accepted commands awaiting a response
  int              gap_q [$];
  int              seed = 6165;
  int              load_cnt = 0;
  int              nrsp = 0;       // Responses taken by the DUT
  int              nexp = 0;
  int              nwrites = 0;

  exu exu_inst (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_valid       (i_valid),
    .o_ready       (o_ready),
    .i_ir          (i_ir),
    .o_agu_valid   (o_agu_valid),
    .o_agu_cmd     (o_agu_cmd),
    .i_agu_ready   (i_agu_ready),
    .i_lsu_valid   (i_lsu_valid),
    .o_lsu_ready   (o_lsu_ready),
    .i_lsu_rsp     (i_lsu_rsp),
    .o_rf_wbck_ena (o_rf_wbck_ena),
    .o_rf_wbck     (o_rf_wbck),
    .o_oitf_empty  (o_oitf_empty),
    .o_exu_active  (o_exu_active)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Reporting and checks
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_wbck(input wbck_t got, input wbck_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: write x%0d=%h, expected x%0d=%h",
                          $time, got.rdidx, got.data, exp.rdidx, exp.data));
    end
  endtask

  task automatic check_agu(input agu_cmd_t got, input agu_cmd_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: load command addr=%h itag=%0d, expected addr=%h itag=%0d",
                          $time, got.addr, got.itag, exp.addr, exp.itag));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  ////////////////////
  // Stimulus table
  function automatic logic [XLEN-1:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  function automatic logic [XLEN-1:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                            input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  task automatic add_step(input logic [XLEN-1:0] ir, input logic err, input logic wen);
    steps[n_built] = {ir, err, wen};
    n_built++;
  endtask

  task automatic build_table();
    add_step(enc_i(OPC_OPIMM, F3_ADD, 1, 0, 100), 1'b0, 1'b1);
    add_step(enc_i(OPC_OPIMM, F3_ADD, 2, 0, -7), 1'b0, 1'b1);
    add_step(enc_r(F7_BASE, F3_ADD, 3, 1, 2), 1'b0, 1'b1);
    add_step(enc_r(F7_SUB, F3_ADD, 4, 1, 2), 1'b0, 1'b1);
    add_step(enc_r(F7_BASE, F3_AND, 5, 1, 2), 1'b0, 1'b1);
    add_step(enc_r(F7_BASE, F3_OR, 6, 1, 2), 1'b0, 1'b1);
    add_step(enc_r(F7_BASE, F3_XOR, 7, 1, 2), 1'b0, 1'b1);
    add_step(enc_r(F7_BASE, F3_SLT, 8, 2, 1), 1'b0, 1'b1);
    add_step(enc_r(F7_BASE, F3_SLT, 9, 1, 2), 1'b0, 1'b1);
    add_step(enc_i(OPC_OPIMM, F3_XOR, 10, 1, 'h555), 1'b0, 1'b1);
    add_step(enc_i(OPC_OPIMM, F3_OR, 11, 2, 'h0f0), 1'b0, 1'b1);
    add_step(enc_i(OPC_OPIMM, F3_AND, 12, 7, -16), 1'b0, 1'b1);
    add_step(enc_r(F7_BASE, F3_ADD, 0, 1, 2), 1'b0, 1'b0);      // Write to x0
    add_step(32'h0000_0000, 1'b0, 1'b0);                         // Illegal opcode
    add_step(enc_r(7'b0000001, F3_ADD, 13, 1, 2), 1'b0, 1'b0);   // MUL is not decoded
    add_step(enc_i(OPC_OPIMM, 3'b010, 20, 1, 5), 1'b0, 1'b0);    // SLTI is not decoded
    add_step(enc_r(F7_BASE, F3_ADD, 13, 0, 1), 1'b0, 1'b1);      // x0 reads zero
    add_step(enc_i(OPC_LOAD, F3_LW, 14, 1, 8), 1'b0, 1'b1);
    add_step(enc_r(F7_BASE, F3_ADD, 15, 14, 1), 1'b0, 1'b1);     // Uses the load result
    add_step(enc_i(OPC_LOAD, F3_LW, 16, 15, -4), 1'b1, 1'b0);    // Error response
    add_step(enc_i(OPC_LOAD, F3_LW, 17, 3, 0), 1'b0, 1'b1);
    add_step(enc_i(OPC_LOAD, F3_LW, 0, 2, 12), 1'b0, 1'b0);
    add_step(enc_i(OPC_OPIMM, F3_ADD, 18, 17, 1), 1'b0, 1'b1);
    add_step(enc_i(OPC_LOAD, F3_LW, 17, 18, 4), 1'b0, 1'b1);     // Same rd as an older load
    add_step(enc_r(F7_SUB, F3_ADD, 19, 17, 16), 1'b0, 1'b1);
    add_step(enc_i(OPC_OPIMM, F3_ADD, 16, 16, 3), 1'b0, 1'b1);
  endtask

  ////////////////////
  // Reference model
  function automatic logic [XLEN-1:0] ref_result(input logic [XLEN-1:0] ir);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = model_rf[ir[19:15]];
    b = model_rf[ir[24:20]];
    if (ir[6:0] != OPC_OP) begin
      b = {{(XLEN-12){ir[31]}}, ir[31:20]};
    end
    if (ir[6:0] == OPC_LOAD) begin
      return a + b;  // Load address
    end
    case (ir[14:12])
      3'b000:  return (ir[6:0] == OPC_OP && ir[30]) ? a - b : a + b;
      3'b010:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // Runs at acceptance, in program order
  task automatic apply_model(input step_t s);
    logic [XLEN-1:0] val;
    logic            is_load;
    wbck_t           w;
    agu_cmd_t        cmd;
    is_load = (s.ir[6:0] == OPC_LOAD) && (s.ir[14:12] == 3'b010);
    val     = ref_result(s.ir);
    if (is_load) begin
      cmd.addr = val;
      cmd.itag = ITAG_W'(load_cnt % OITF_DEPTH);  // Entries allocated round robin
      agu_exp_q.push_back(cmd);
      err_q.push_back(s.err);
      load_cnt++;
      val = val ^ LOAD_XOR;
    end
    if (s.wen) begin
      model_rf[s.ir[11:7]] = val;
      w.rdidx = s.ir[11:7];
      w.data  = val;
      exp_q.push_back(w);
      nexp++;
    end
  endtask

  ////////////////////
  // Load unit
  initial begin : agu_stall
    i_agu_ready = 1'b0;
    forever begin
      @(negedge clk);
      i_agu_ready = (($random(seed) & 3) != 0);
    end
  end

  always @(posedge clk) begin : agu_monitor
    agu_cmd_t exp_cmd;
    lsu_rsp_t rsp;
    if (!i_rst && o_agu_valid && i_agu_ready) begin
      if (agu_exp_q.size() == 0) begin
        abort_run("A load command was issued with no load outstanding");
      end else begin
        exp_cmd = agu_exp_q.pop_front();
        check_agu(o_agu_cmd, exp_cmd);
        rsp.data = exp_cmd.addr ^ LOAD_XOR;
        rsp.itag = exp_cmd.itag;
        rsp.err  = err_q.pop_front();
        rsp_q.push_back(rsp);
        gap_q.push_back($random(seed) & 7);
      end
    end
  end

  initial begin : load_responder
    lsu_rsp_t rsp;
    int       gap;
    i_lsu_valid = 1'b0;
    i_lsu_rsp   = '0;
    forever begin
      @(negedge clk);
      if (rsp_q.size() != 0) begin
        rsp = rsp_q.pop_front();
        gap = gap_q.pop_front();
        repeat (gap) @(negedge clk);
        i_lsu_rsp   = rsp;
        i_lsu_valid = 1'b1;
        @(posedge clk);
        while (!o_lsu_ready) @(posedge clk);
        nrsp++;
        @(negedge clk);
        i_lsu_valid = 1'b0;
      end
    end
  end

  // Oldest pending write to this rd must match
  always @(posedge clk) begin : wbck_monitor
    int idx;
    if (!i_rst && o_rf_wbck_ena) begin
      idx = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
        if (idx < 0 && exp_q[i].rdidx == o_rf_wbck.rdidx) idx = i;
      end
      if (idx < 0) begin
        abort_run($sformatf("ERR %0t: unexpected write to x%0d", $time, o_rf_wbck.rdidx));
      end else begin
        check_wbck(o_rf_wbck, exp_q[idx]);
        exp_q.delete(idx);
        nwrites++;
      end
    end
  end

  initial begin : watchdog
    #(CLK_PERIOD * WD_CYCLES);
    abort_run($sformatf("Timeout: the run did not finish within %0d cycles", WD_CYCLES));
  end

  ////////////////////
  // Main sequence
  initial begin : main
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_ir    = '0;
    for (int r = 0; r < RF_NUM; r++) model_rf[r] = '0;
    build_table();
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;
    check_flag("o_agu_valid", o_agu_valid, 1'b0);
    check_flag("o_rf_wbck_ena", o_rf_wbck_ena, 1'b0);
    check_flag("o_lsu_ready", o_lsu_ready, 1'b0);
    check_flag("o_oitf_empty", o_oitf_empty, 1'b1);

    for (int k = 0; k < N_STEPS; k++) begin
      i_valid = 1'b1;
      i_ir    = steps[k].ir;
      @(posedge clk);
      while (!o_ready) @(posedge clk);
      check_flag("o_exu_active", o_exu_active, 1'b1);
      apply_model(steps[k]);
      @(negedge clk);
    end
    i_valid = 1'b0;

    // Wait until every load has been answered
    while (nrsp < load_cnt) @(negedge clk);
    repeat (4) @(negedge clk);  // Last ALU results write back within these cycles

    if (nwrites == nexp && o_oitf_empty && !o_exu_active) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run($sformatf("ERR %0t: %0d writes for %0d expected, oitf_empty=%b active=%b",
                          $time, nwrites, nexp, o_oitf_empty, o_exu_active));
    end
  end

endmodule

`default_nettype wire

//--- all.f
hdl/exu_pkg.sv
hdl/exu_decode.sv
hdl/exu_regfile.sv
hdl/exu_oitf.sv
hdl/exu_disp.sv
hdl/exu_alu.sv
hdl/exu_wbck.sv
hdl/exu.sv
testbench/exu_properties.sv
testbench/tb_exu.sv

//--- run.sh
#!/bin/sh
# Build and run the execution-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_exu -o tb_exu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_exu_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
  exit 0
fi
exit 1
